/* logic/fifo_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_ctrl_fsm #(
    parameter bit                  OFLOW_PROT  = 1'b1,
    parameter bit                  UFLOW_PROT  = 1'b1,
    parameter fifo_pkg::opt_mode_t WR_OPT_MODE = fifo_pkg::OPT_MODE_TIMING,
    parameter fifo_pkg::opt_mode_t RD_OPT_MODE = fifo_pkg::OPT_MODE_TIMING
) (
    input  logic                         wr_clk,
    input  logic                         rd_srst,

    // Write side
    input  logic                         wr,
    output logic                         wr_rdy,
    output logic                         wr_safe,
    output logic [fifo_pkg::PTR_WID-1:0] wr_ptr,
    output logic [fifo_pkg::CNT_WID-1:0] wr_count,
    output logic                         wr_full,
    output logic                         wr_oflow,

    // Read side
    input  logic                         rd,
    output logic                         rd_safe,
    output logic [fifo_pkg::PTR_WID-1:0] rd_ptr,
    output logic [fifo_pkg::CNT_WID-1:0] rd_count,
    output logic                         rd_empty,
    output logic                         rd_uflow,

    // Storage finished its clearing pass
    input  logic                         mem_rdy
);

    // Pointers carry one extra wrap bit
    logic [fifo_pkg::CNT_WID-1:0] wr_ptr_q;
    logic [fifo_pkg::CNT_WID-1:0] rd_ptr_q;

    // Current fill level from the pointer difference
    logic [fifo_pkg::CNT_WID-1:0] fill_cnt;

    // --------------------------------------------------
    // Write pointer
    // --------------------------------------------------
    assign wr_safe  = OFLOW_PROT ? (wr && wr_rdy) : wr;
    assign wr_oflow = wr && !wr_rdy;

    always_ff @(posedge wr_clk) begin
        if (rd_srst) begin
            wr_ptr_q <= '0;
        end else if (wr_safe) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    assign wr_ptr = wr_ptr_q[fifo_pkg::PTR_WID-1:0];

    // --------------------------------------------------
    // Read pointer
    // --------------------------------------------------
    assign rd_safe  = UFLOW_PROT ? (rd && !rd_empty) : rd;
    assign rd_uflow = rd && rd_empty;

    always_ff @(posedge wr_clk) begin
        if (rd_srst) begin
            rd_ptr_q <= '0;
        end else if (rd_safe) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    assign rd_ptr = rd_ptr_q[fifo_pkg::PTR_WID-1:0];

    // Wrap bit makes this exact for 0..DEPTH
    assign fill_cnt = wr_ptr_q - rd_ptr_q;

    // --------------------------------------------------
    // Write-side status
    // --------------------------------------------------
    generate
        if (WR_OPT_MODE == fifo_pkg::OPT_MODE_TIMING) begin : g_wr_timing
            // Writes show up at once, reads a cycle late
            always_ff @(posedge wr_clk) begin
                if (rd_srst) begin
                    wr_count <= '0;
                    wr_full  <= 1'b0;
                end else if (wr_safe) begin
                    wr_count <= fill_cnt + 1'b1;
                    wr_full  <= (fill_cnt >= fifo_pkg::CNT_ALMOST);
                end else begin
                    wr_count <= fill_cnt;
                    wr_full  <= (fill_cnt == fifo_pkg::CNT_FULL);
                end
            end

            // Held low until storage is cleared
            always_ff @(posedge wr_clk) begin
                if (rd_srst || !mem_rdy) begin
                    wr_rdy <= 1'b0;
                end else if (wr_safe) begin
                    wr_rdy <= (fill_cnt < fifo_pkg::CNT_ALMOST);
                end else begin
                    wr_rdy <= (fill_cnt < fifo_pkg::CNT_FULL);
                end
            end
        end : g_wr_timing
        else begin : g_wr_latency
            assign wr_count = fill_cnt;
            assign wr_full  = (fill_cnt == fifo_pkg::CNT_FULL);
            assign wr_rdy   = mem_rdy && (fill_cnt < fifo_pkg::CNT_FULL);
        end : g_wr_latency
    endgenerate

    // --------------------------------------------------
    // Read-side status
    // --------------------------------------------------
    generate
        if (RD_OPT_MODE == fifo_pkg::OPT_MODE_TIMING) begin : g_rd_timing
            // Reads show up at once, writes a cycle late
            always_ff @(posedge wr_clk) begin
                if (rd_srst) begin
                    rd_count <= '0;
                    rd_empty <= 1'b1;
                end else if (rd_safe) begin
                    rd_count <= fill_cnt - 1'b1;
                    // Level of one or less drains to empty
                    rd_empty <= (fill_cnt[fifo_pkg::CNT_WID-1:1] == '0);
                end else begin
                    rd_count <= fill_cnt;
                    rd_empty <= (fill_cnt == '0);
                end
            end
        end : g_rd_timing
        else begin : g_rd_latency
            assign rd_count = fill_cnt;
            assign rd_empty = (fill_cnt == '0);
        end : g_rd_latency
    endgenerate

endmodule : fifo_ctrl_fsm

`default_nettype wire

/* logic/fifo_fwft.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_fwft (
    input  logic                          wr_clk,
    input  logic                          rd_srst,

    // Controller side
    input  logic                          rd_empty,
    output logic                          rd,
    input  logic [fifo_pkg::DATA_WID-1:0] mem_rd_data,

    // Output stream
    output logic                          out_valid,
    output logic [fifo_pkg::DATA_WID-1:0] out_data,
    input  logic                          out_ready
);

    // Head slot faces the output, skid slot sits behind it
    logic                          head_vld;
    logic [fifo_pkg::DATA_WID-1:0] head_data;
    logic                          skid_vld;
    logic [fifo_pkg::DATA_WID-1:0] skid_data;

    // Read issued last cycle, data lands this cycle
    logic                          rd_pend;

    // Slots taken or already promised
    logic [1:0]                    occupancy;
    logic                          pop;

    assign occupancy = {1'b0, head_vld} + {1'b0, skid_vld} + {1'b0, rd_pend};

    // Only read when the word is sure to find a slot
    assign rd  = !rd_empty && (occupancy < 2'd2);
    assign pop = head_vld && out_ready;

    // --------------------------------------------------
    // Slot control
    // --------------------------------------------------
    always_ff @(posedge wr_clk) begin
        if (rd_srst) begin
            head_vld <= 1'b0;
            skid_vld <= 1'b0;
            rd_pend  <= 1'b0;
        end else begin
            rd_pend <= rd;
            if (pop) begin
                // Skid moves up, or arriving word takes the head
                head_vld <= skid_vld || rd_pend;
                skid_vld <= skid_vld && rd_pend;
            end else if (rd_pend) begin
                if (head_vld) begin
                    skid_vld <= 1'b1;
                end else begin
                    head_vld <= 1'b1;
                end
            end
        end
    end

    // --------------------------------------------------
    // Slot data
    // --------------------------------------------------
    always_ff @(posedge wr_clk) begin
        if (pop) begin
            if (skid_vld) begin
                head_data <= skid_data;
                if (rd_pend) begin
                    skid_data <= mem_rd_data;
                end
            end else if (rd_pend) begin
                head_data <= mem_rd_data;
            end
        end else if (rd_pend) begin
            if (head_vld) begin
                skid_data <= mem_rd_data;
            end else begin
                head_data <= mem_rd_data;
            end
        end
    end

    assign out_valid = head_vld;
    assign out_data  = head_data;

endmodule : fifo_fwft

`default_nettype wire

/* logic/fifo_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_mem (
    input  logic                          wr_clk,
    input  logic                          rd_srst,

    // Write port
    input  logic                          wr_safe,
    input  logic [fifo_pkg::PTR_WID-1:0]  wr_ptr,
    input  logic [fifo_pkg::DATA_WID-1:0] wr_data,

    // Read port, one cycle of latency
    input  logic                          rd_safe,
    input  logic [fifo_pkg::PTR_WID-1:0]  rd_ptr,
    output logic [fifo_pkg::DATA_WID-1:0] mem_rd_data,

    // High once every address is cleared
    output logic                          mem_rdy
);

    logic [fifo_pkg::DATA_WID-1:0] mem [fifo_pkg::DEPTH];

    // Address walked by the clearing pass
    logic [fifo_pkg::PTR_WID-1:0]  clr_addr;

    // Write port mux between clearing and normal traffic
    logic                          mem_we;
    logic [fifo_pkg::PTR_WID-1:0]  mem_waddr;
    logic [fifo_pkg::DATA_WID-1:0] mem_wdata;

    // --------------------------------------------------
    // Clearing pass
    // --------------------------------------------------
    // One address per edge, mem_rdy on the last one
    always_ff @(posedge wr_clk) begin
        if (rd_srst) begin
            clr_addr <= '0;
            mem_rdy  <= 1'b0;
        end else if (!mem_rdy) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == fifo_pkg::PTR_LAST) begin
                mem_rdy <= 1'b1;
            end
        end
    end

    always_comb begin
        if (mem_rdy) begin
            mem_we    = wr_safe;
            mem_waddr = wr_ptr;
            mem_wdata = wr_data;
        end else begin
            // Zero fill while clearing
            mem_we    = 1'b1;
            mem_waddr = clr_addr;
            mem_wdata = '0;
        end
    end

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    always_ff @(posedge wr_clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
    end

    // Registered read
    always_ff @(posedge wr_clk) begin
        if (rd_safe) begin
            mem_rd_data <= mem[rd_ptr];
        end
    end

endmodule : fifo_mem

`default_nettype wire

/* logic/fifo_pkg.sv */
`default_nettype none

package fifo_pkg;

    // --------------------------------------------------
    // Geometry
    // --------------------------------------------------
    localparam int DEPTH    = 16;
    localparam int DATA_WID = 8;

    // Address into the storage array
    localparam int PTR_WID = $clog2(DEPTH);

    // Wide enough to hold DEPTH itself
    localparam int CNT_WID = $clog2(DEPTH + 1);

    // Count values used by the flag logic
    localparam logic [CNT_WID-1:0] CNT_FULL   = CNT_WID'(DEPTH);
    localparam logic [CNT_WID-1:0] CNT_ALMOST = CNT_WID'(DEPTH - 1);

    // Last address of the clearing pass
    localparam logic [PTR_WID-1:0] PTR_LAST = PTR_WID'(DEPTH - 1);

    // --------------------------------------------------
    // Flag optimisation mode
    // --------------------------------------------------
    // TIMING registers counts and flags,
    // LATENCY derives them straight from the pointers
    typedef enum logic [1:0] {
        OPT_MODE_TIMING  = 2'd0,
        OPT_MODE_LATENCY = 2'd1
    } opt_mode_t;

    // Modes used by the top level
    localparam opt_mode_t WR_MODE = OPT_MODE_TIMING;
    localparam opt_mode_t RD_MODE = OPT_MODE_TIMING;

endpackage : fifo_pkg

`default_nettype wire

/* logic/fifo_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_sync (
    input  logic                          wr_clk,
    input  logic                          rd_srst,

    // Byte input
    input  logic                          wr,
    input  logic [fifo_pkg::DATA_WID-1:0] wr_data,
    output logic                          wr_rdy,
    output logic                          wr_full,
    output logic                          wr_oflow,
    output logic [fifo_pkg::CNT_WID-1:0]  wr_count,

    // Byte output stream
    output logic                          out_valid,
    output logic [fifo_pkg::DATA_WID-1:0] out_data,
    input  logic                          out_ready
);

    // --------------------------------------------------
    // Internal nets
    // --------------------------------------------------
    logic                          wr_safe;
    logic [fifo_pkg::PTR_WID-1:0]  wr_ptr;
    logic                          rd;
    logic                          rd_safe;
    logic [fifo_pkg::PTR_WID-1:0]  rd_ptr;
    logic                          rd_empty;
    logic                          mem_rdy;
    logic [fifo_pkg::DATA_WID-1:0] mem_rd_data;

    // Pointer and flag control
    fifo_ctrl_fsm #(
        .OFLOW_PROT  (1'b1),
        .UFLOW_PROT  (1'b1),
        .WR_OPT_MODE (fifo_pkg::WR_MODE),
        .RD_OPT_MODE (fifo_pkg::RD_MODE)
    ) u_ctrl (
        .wr_clk   (wr_clk),
        .rd_srst  (rd_srst),
        .wr       (wr),
        .wr_rdy   (wr_rdy),
        .wr_safe  (wr_safe),
        .wr_ptr   (wr_ptr),
        .wr_count (wr_count),
        .wr_full  (wr_full),
        .wr_oflow (wr_oflow),
        .rd       (rd),
        .rd_safe  (rd_safe),
        .rd_ptr   (rd_ptr),
        .rd_count (),
        .rd_empty (rd_empty),
        .rd_uflow (),
        .mem_rdy  (mem_rdy)
    );

    // Byte storage with clearing pass
    fifo_mem u_mem (
        .wr_clk      (wr_clk),
        .rd_srst     (rd_srst),
        .wr_safe     (wr_safe),
        .wr_ptr      (wr_ptr),
        .wr_data     (wr_data),
        .rd_safe     (rd_safe),
        .rd_ptr      (rd_ptr),
        .mem_rd_data (mem_rd_data),
        .mem_rdy     (mem_rdy)
    );

    // Prefetch into the output stream
    fifo_fwft u_fwft (
        .wr_clk      (wr_clk),
        .rd_srst     (rd_srst),
        .rd_empty    (rd_empty),
        .rd          (rd),
        .mem_rd_data (mem_rd_data),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_ready   (out_ready)
    );

endmodule : fifo_sync

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=fifo_sync_tb
BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" --Mdir "$BUILD_DIR" -o "$TOP" -f src.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

"./$BUILD_DIR/$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit "$status"
fi

exit 0

/* src.f */
logic/fifo_pkg.sv
logic/fifo_ctrl_fsm.sv
logic/fifo_mem.sv
logic/fifo_fwft.sv
logic/fifo_sync.sv
verification/fifo_sync_sva.sv
verification/fifo_sync_tb.sv

/* verification/fifo_sync_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_sync_sva (
    input logic                          wr_clk,
    input logic                          rd_srst,
    input logic                          rd_uflow,
    input logic [fifo_pkg::CNT_WID-1:0]  wr_count,
    input logic                          wr_full,
    input logic                          out_valid,
    input logic                          out_ready,
    input logic [fifo_pkg::DATA_WID-1:0] out_data
);

    // --------------------------------------------------
    // Controller
    // --------------------------------------------------
    // Output stage only reads when not empty
    a_no_uflow : assert property (@(posedge wr_clk) disable iff (rd_srst) !rd_uflow)
        else $error("rd_uflow went high");

    a_count_max : assert property (@(posedge wr_clk) disable iff (rd_srst)
        wr_count <= fifo_pkg::CNT_FULL)
        else $error("wr_count above DEPTH: %0d", wr_count);

    a_full_flag : assert property (@(posedge wr_clk) disable iff (rd_srst)
        wr_full == (wr_count == fifo_pkg::CNT_FULL))
        else $error("wr_full disagrees with wr_count %0d", wr_count);

    // --------------------------------------------------
    // Output stream
    // --------------------------------------------------
    a_hold_data : assert property (@(posedge wr_clk) disable iff (rd_srst)
        out_valid && !out_ready |=> $stable(out_data))
        else $error("out_data changed while the stream was stalled");

endmodule : fifo_sync_sva

// Stream ports tied off here
bind fifo_ctrl_fsm fifo_sync_sva u_sva_ctrl (
    .wr_clk (wr_clk), .rd_srst (rd_srst), .rd_uflow (rd_uflow),
    .wr_count (wr_count), .wr_full (wr_full),
    .out_valid (1'b0), .out_ready (1'b0), .out_data ('0)
);

// Controller ports tied off here
bind fifo_fwft fifo_sync_sva u_sva_fwft (
    .wr_clk (wr_clk), .rd_srst (rd_srst), .rd_uflow (1'b0),
    .wr_count ('0), .wr_full (1'b0),
    .out_valid (out_valid), .out_ready (out_ready), .out_data (out_data)
);

`default_nettype wire

/* verification/fifo_sync_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_sync_tb;

    localparam int          CLK_PERIOD    = 100;
    localparam int          RESET_CYCLES  = 5;
    localparam int unsigned SEED          = 32'h352;
    localparam int          DEPTH         = fifo_pkg::DEPTH;
    localparam int          DATA_WID      = fifo_pkg::DATA_WID;
    localparam int          RANDOM_CYCLES = 400;
    localparam int          RESUME_CYCLES = 200;
    localparam int          PRELOAD_WORDS = 6;
    localparam int          FILL_LIMIT    = 2 * DEPTH + 8;
    localparam int          DRAIN_LIMIT   = 4 * (DEPTH + 2);
    localparam int          SETTLE_CYCLES = DEPTH + 4;
    localparam int          TOTAL_CYCLES  = 2 * (RESET_CYCLES + DEPTH + 2) + RANDOM_CYCLES
        + RESUME_CYCLES + FILL_LIMIT + PRELOAD_WORDS + 3 * (DRAIN_LIMIT + SETTLE_CYCLES);
    localparam int          TIMEOUT_NS    = (TOTAL_CYCLES + 100) * CLK_PERIOD;

    logic                         wr_clk;
    logic                         rd_srst;
    logic                         wr;
    logic [DATA_WID-1:0]          wr_data;
    logic                         wr_rdy;
    logic                         wr_full;
    logic                         wr_oflow;
    logic [fifo_pkg::CNT_WID-1:0] wr_count;
    logic                         out_valid;
    logic [DATA_WID-1:0]          out_data;
    logic                         out_ready;

    // Accepted words waiting for the output with the oldest at the front
    logic [DATA_WID-1:0]          model [$];

    fifo_sync UUT (
        .wr_clk    (wr_clk),
        .rd_srst   (rd_srst),
        .wr        (wr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .wr_full   (wr_full),
        .wr_oflow  (wr_oflow),
        .wr_count  (wr_count),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

    initial begin
        wr_clk = 1'b0;
        forever #(CLK_PERIOD / 2) wr_clk = ~wr_clk;
    end

    // --------------------------------------------------
    // Checking
    // --------------------------------------------------
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "Testbench stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h",
                                        name, got, exp));
        end
    endtask

    // Drive 1 ns after the rise and check at the fall
    task automatic run_cycle(input logic wr_en, input logic [DATA_WID-1:0] data,
                             input logic ready);
        @(posedge wr_clk);
        #1;
        wr        = wr_en;
        wr_data   = data;
        out_ready = ready;
        @(negedge wr_clk);
        compare_value("wr_oflow", 32'(wr_oflow), 32'(wr && !wr_rdy));
        // A word written in this cycle cannot reach the output yet
        if (out_valid) begin
            if (model.size() == 0) begin
                stop_with_failure("Output presented a word that was never written");
            end
            compare_value("out_data", 32'(out_data), 32'(model[0]));
            if (out_ready) begin
                void'(model.pop_front());
            end
        end
        if (wr && wr_rdy) begin
            model.push_back(wr_data);
        end
    endtask

    // --------------------------------------------------
    // Test phases
    // --------------------------------------------------
    task automatic apply_reset();
        rd_srst   = 1'b1;
        wr        = 1'b0;
        out_ready = 1'b0;
        model.delete();
        repeat (RESET_CYCLES) @(posedge wr_clk);
        #1;
        rd_srst = 1'b0;
        @(negedge wr_clk);
        compare_value("wr_rdy", 32'(wr_rdy), 0);
        compare_value("out_valid", 32'(out_valid), 0);
        compare_value("wr_full", 32'(wr_full), 0);
        compare_value("wr_oflow", 32'(wr_oflow), 0);
        compare_value("wr_count", 32'(wr_count), 0);
    endtask

    // Ready comes one edge after the last cleared address
    task automatic check_clearing_pass();
        int k;
        for (k = 1; k <= DEPTH + 1; k++) begin
            run_cycle(k == DEPTH / 2, DATA_WID'(k), 1'b1);
            compare_value("wr_rdy", 32'(wr_rdy), 32'(k == DEPTH + 1));
            compare_value("wr_count", 32'(wr_count), 0);
        end
    endtask

    task automatic random_traffic(input int cycles);
        repeat (cycles) begin
            run_cycle(($urandom % 4) != 0, DATA_WID'($urandom), ($urandom % 2) == 1);
        end
    endtask

    task automatic drain_and_settle();
        int n;
        n = 0;
        while (model.size() != 0) begin
            if (n == DRAIN_LIMIT) begin
                stop_with_failure("Drain did not deliver every queued word in time");
            end
            run_cycle(1'b0, '0, 1'b1);
            n++;
        end
        repeat (SETTLE_CYCLES) run_cycle(1'b0, '0, 1'b1);
        compare_value("out_valid", 32'(out_valid), 0);
        compare_value("wr_count", 32'(wr_count), 0);
    endtask

    // Output held off so the memory and both stage slots fill
    task automatic fill_test();
        int accepted;
        accepted = 0;
        run_cycle(1'b1, DATA_WID'($urandom), 1'b0);
        while (wr_rdy) begin
            accepted++;
            if (accepted > FILL_LIMIT) begin
                stop_with_failure("Write side never reported full");
            end
            run_cycle(1'b1, DATA_WID'($urandom), 1'b0);
        end
        compare_value("accepted words", 32'(accepted), DEPTH + 2);
        compare_value("wr_full", 32'(wr_full), 1);
        compare_value("wr_count", 32'(wr_count), DEPTH);
    endtask

    task automatic reset_with_data();
        repeat (PRELOAD_WORDS) run_cycle(1'b1, DATA_WID'($urandom), 1'b0);
        run_cycle(1'b0, '0, 1'b0);
        if (model.size() == 0) begin
            stop_with_failure("No data was queued before the mid-run reset");
        end
        @(posedge wr_clk);
        #1;
        apply_reset();
        check_clearing_pass();
    endtask

    initial begin
        rd_srst   = 1'b1;
        wr        = 1'b0;
        wr_data   = '0;
        out_ready = 1'b0;
        void'($urandom(SEED));
        apply_reset();
        check_clearing_pass();
        random_traffic(RANDOM_CYCLES);
        drain_and_settle();
        fill_test();
        drain_and_settle();
        reset_with_data();
        random_traffic(RESUME_CYCLES);
        drain_and_settle();
        $display("Simulation finished: PASS");
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        stop_with_failure("Watchdog timeout, the tests did not finish in time");
    end

endmodule : fifo_sync_tb

`default_nettype wire
